/* decode_stage.f */
+incdir+design
design/rv_decode_pkg.sv
design/instr_fetch.sv
design/decode_ctl.sv
design/imm_gen.sv
design/decode_stage.sv
verification/decode_stage_checker.sv
verification/decode_stage_tb.sv

/* design/decode_ctl.sv */
module decode_ctl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance,
    input  rv_decode_pkg::fetch_t   fetch,
    output rv_decode_pkg::fetch_t   dec,
    output rv_decode_pkg::opcode_e  opcode,
    output rv_decode_pkg::imm_sel_e imm_sel,
    output logic                    illegal
);

    import rv_decode_pkg::*;

    opcode_e  opcode_d;
    imm_sel_e imm_sel_d;
    logic     illegal_d;

    logic        dec_valid;
    logic [31:0] dec_pc;
    logic [31:0] dec_instr;

    // Raw opcode bits, kept even when they name no RV32I class
    assign opcode_d = opcode_e'(fetch.instr[6:0]);

    // Opcode to immediate format
    always_comb begin
        illegal_d = 1'b0;
        case (opcode_d)
            LUI, AUIPC:          imm_sel_d = IMM_U;
            JAL:                 imm_sel_d = IMM_J;
            JALR, LOAD, OP_IMM:  imm_sel_d = IMM_I;
            STORE:               imm_sel_d = IMM_S;
            BRANCH:              imm_sel_d = IMM_B;
            // Register ops, FENCE and SYSTEM carry no immediate
            OP, MISC_MEM, SYSTEM: imm_sel_d = IMM_R;
            default: begin
                // Unknown opcode
                imm_sel_d = IMM_R;
                illegal_d = 1'b1;
            end
        endcase
    end

    // Control side, reset to a U-format select
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
            opcode    <= LUI;
            imm_sel   <= IMM_U;
            illegal   <= 1'b0;
        end else if (advance) begin
            // Empties when the buffer is empty
            dec_valid <= fetch.valid;
            opcode    <= opcode_d;
            imm_sel   <= imm_sel_d;
            illegal   <= illegal_d;
        end
    end

    // Instruction and PC follow the same load
    always_ff @(posedge clk) begin
        if (advance) begin
            dec_pc    <= fetch.pc;
            dec_instr <= fetch.instr;
        end
    end

    assign dec.valid = dec_valid;
    assign dec.pc    = dec_pc;
    assign dec.instr = dec_instr;

endmodule

/* design/decode_stage.sv */
module decode_stage (
    input  logic                    clk,
    input  logic                    rst,
    output rv_decode_pkg::wb_req_t  wb_req,
    input  rv_decode_pkg::wb_rsp_t  wb_rsp,
    input  logic                    out_ready,
    output logic                    out_valid,
    output rv_decode_pkg::decoded_t out
);

    import rv_decode_pkg::*;

    // Shared stall/advance from the output slot
    logic     advance;

    // Fetch buffer to decode
    fetch_t   fetch;

    // Decode register to immediate stage
    fetch_t   dec;
    opcode_e  opcode;
    imm_sel_e imm_sel;
    logic     illegal;

    instr_fetch u_fetch (
        .clk     (clk),
        .rst     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .advance (advance),
        .fetch   (fetch)
    );

    decode_ctl u_decode_ctl (
        .clk     (clk),
        .rst     (rst),
        .advance (advance),
        .fetch   (fetch),
        .dec     (dec),
        .opcode  (opcode),
        .imm_sel (imm_sel),
        .illegal (illegal)
    );

    // Last stage, owns the output handshake
    imm_gen u_imm_gen (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .opcode    (opcode),
        .imm_sel   (imm_sel),
        .illegal   (illegal),
        .advance   (advance),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

/* design/imm_gen.sv */
module imm_gen (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_decode_pkg::fetch_t   dec,
    input  rv_decode_pkg::opcode_e  opcode,
    input  rv_decode_pkg::imm_sel_e imm_sel,
    input  logic                    illegal,
    output logic                    advance,
    input  logic                    out_ready,
    output logic                    out_valid,
    output rv_decode_pkg::decoded_t out
);

    import rv_decode_pkg::*;

    logic [31:0] ins;
    logic [31:0] imm_d;
    decoded_t    out_q;

    assign ins = dec.instr;

    // Whole pipe moves when the output slot is free or being taken
    assign advance = !out_valid || out_ready;

    // Standard RV32I immediate layouts
    always_comb begin
        case (imm_sel)
            IMM_I: imm_d = {{20{ins[31]}}, ins[31:20]};
            IMM_S: imm_d = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            // Branch offset, bit 0 always zero
            IMM_B: imm_d = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            // Upper 20 bits, low 12 cleared
            IMM_U: imm_d = {ins[31:12], 12'b0};
            IMM_J: imm_d = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default: imm_d = 32'b0;
        endcase
    end

    // Output slot valid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= dec.valid;
        end
    end

    // Bundle held steady while stalled
    always_ff @(posedge clk) begin
        if (advance) begin
            out_q.pc      <= dec.pc;
            out_q.instr   <= dec.instr;
            out_q.opcode  <= opcode;
            out_q.imm_sel <= imm_sel;
            out_q.imm     <= imm_d;
            out_q.illegal <= illegal;
        end
    end

    assign out = out_q;

endmodule

/* design/instr_fetch.sv */
`include "rv_decode_defines.svh"

module instr_fetch (
    input  logic                   clk,
    input  logic                   rst,
    output rv_decode_pkg::wb_req_t wb_req,
    input  rv_decode_pkg::wb_rsp_t wb_rsp,
    input  logic                   advance,
    output rv_decode_pkg::fetch_t  fetch
);

    // Bus cycle FSM
    // IDLE waits for buffer space, BUS holds cyc/stb until ack
    typedef enum logic {
        IDLE,
        BUS
    } state_e;

    state_e      state_q;
    logic [31:0] pc_q;

    // One-word fetch buffer
    logic        buf_valid;
    logic [31:0] buf_pc;
    logic [31:0] buf_instr;

    logic        buf_free;
    logic        bus_done;

    // Room for a new word
    // either empty or drained by decode this cycle
    assign buf_free = !buf_valid || advance;

    // Ack only counts inside our own cycle
    assign bus_done = (state_q == BUS) && wb_rsp.ack;

    // Strobe straight from the state, adr from the PC register
    assign wb_req.cyc = (state_q == BUS);
    assign wb_req.stb = (state_q == BUS);
    assign wb_req.we  = 1'b0;
    assign wb_req.adr = pc_q;
    assign wb_req.sel = `RV_WB_SEL;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
            pc_q    <= `RV_RESET_PC;
        end else begin
            case (state_q)
                IDLE: begin
                    // Start only when the word can land somewhere
                    if (buf_free) begin
                        state_q <= BUS;
                    end
                end
                BUS: begin
                    // Drop cyc/stb the cycle after ack
                    if (wb_rsp.ack) begin
                        state_q <= IDLE;
                        pc_q    <= pc_q + `RV_INSTR_BYTES;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Buffer occupancy
    // a fill always wins, the buffer is empty during any bus cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (bus_done) begin
            buf_valid <= 1'b1;
        end else if (advance) begin
            buf_valid <= 1'b0;
        end
    end

    // Word and address captured on ack
    always_ff @(posedge clk) begin
        if (bus_done) begin
            buf_pc    <= pc_q;
            buf_instr <= wb_rsp.dat;
        end
    end

    assign fetch.valid = buf_valid;
    assign fetch.pc    = buf_pc;
    assign fetch.instr = buf_instr;

endmodule

/* design/rv_decode_defines.svh */
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

// Address of the first instruction fetched after reset
// Word aligned, the fetch unit only ever adds 4
`define RV_RESET_PC 32'h0000_0000

// Byte lanes for a full 32-bit word read
// Fetch never issues partial reads
`define RV_WB_SEL 4'hF

// Bytes per instruction word
`define RV_INSTR_BYTES 32'd4

`endif

/* design/rv_decode_pkg.sv */
package rv_decode_pkg;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        BRANCH   = 7'b1100011,
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        OP_IMM   = 7'b0010011,
        OP       = 7'b0110011,
        MISC_MEM = 7'b0001111,
        SYSTEM   = 7'b1110011
    } opcode_e;

    // Immediate formats
    // R means no immediate, imm is zero
    typedef enum logic [2:0] {
        IMM_R = 3'd0,
        IMM_I = 3'd1,
        IMM_S = 3'd2,
        IMM_B = 3'd3,
        IMM_U = 3'd4,
        IMM_J = 3'd5
    } imm_sel_e;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [3:0]  sel;
    } wb_req_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // One fetched word with its address
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_t;

    // Bundle handed to the next pipeline stage
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        opcode_e     opcode;
        imm_sel_e    imm_sel;
        logic [31:0] imm;
        logic        illegal;
    } decoded_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the decode_stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f decode_stage.f --top-module decode_stage_tb

# Keep running past assertion failures so the summary gets printed
status=0
./obj_dir/Vdecode_stage_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit "$status"

/* verification/decode_stage_checker.sv */
`include "rv_decode_defines.svh"

module decode_stage_checker (
    input logic                    clk,
    input logic                    rst,
    input rv_decode_pkg::wb_req_t  wb_req,
    input rv_decode_pkg::wb_rsp_t  wb_rsp,
    input logic                    out_ready,
    input logic                    out_valid,
    input rv_decode_pkg::decoded_t out
);

    import rv_decode_pkg::*;

    // Number of failed assertions
    int unsigned fail_count = 0;

    // Bundles taken by the sink so far
    logic [31:0] accepted_cnt;

    // Expected format per opcode
    // Unknown opcodes land on R
    function automatic imm_sel_e format_of(input logic [6:0] op);
        case (op)
            LUI, AUIPC:         return IMM_U;
            JAL:                return IMM_J;
            JALR, LOAD, OP_IMM: return IMM_I;
            STORE:              return IMM_S;
            BRANCH:             return IMM_B;
            default:            return IMM_R;
        endcase
    endfunction

    function automatic logic known_opcode(input logic [6:0] op);
        return op inside {LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE,
            OP_IMM, OP, MISC_MEM, SYSTEM};
    endfunction

    // Field placed at the top of the word and shifted down with sign
    function automatic logic [31:0] imm_of(input logic [31:0] i, input imm_sel_e f);
        case (f)
            IMM_I:   return $signed(i) >>> 20;
            IMM_S:   return $signed({i[31:25], i[11:7], 20'b0}) >>> 20;
            IMM_B:   return $signed({i[31], i[7], i[30:25], i[11:8], 1'b0, 19'b0}) >>> 19;
            IMM_U:   return {i[31:12], 12'b0};
            IMM_J:   return $signed({i[31], i[19:12], i[20], i[30:21], 1'b0, 11'b0}) >>> 11;
            default: return 32'b0;
        endcase
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            accepted_cnt <= 32'd0;
        end else if (out_valid && out_ready) begin
            accepted_cnt <= accepted_cnt + 32'd1;
        end
    end

    // Pending request holds stb and adr until ack
    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr))
        else begin
            $error("Error at %0t: stb or adr changed before ack", $time);
            fail_count++;
        end

    // Full-word reads with cyc and stb raised together
    a_wb_fields: assert property (@(posedge clk) disable iff (rst)
        !wb_req.we && wb_req.sel == `RV_WB_SEL && wb_req.cyc == wb_req.stb)
        else begin
            $error("Error at %0t: cyc %b stb %b we %b sel %h on the bus", $time,
                wb_req.cyc, wb_req.stb, wb_req.we, wb_req.sel);
            fail_count++;
        end

    // Stalled bundle stays put
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out))
        else begin
            $error("Error at %0t: output changed while stalled", $time);
            fail_count++;
        end

    // Sequential PCs from the reset vector
    a_pc_order: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready |-> out.pc == `RV_RESET_PC + {accepted_cnt[29:0], 2'b00})
        else begin
            $error("Error at %0t: pc %h for bundle %0d", $time, out.pc, accepted_cnt);
            fail_count++;
        end

    // Opcode class, format, illegal flag and immediate
    a_decode: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out.opcode == out.instr[6:0]
            && out.imm_sel == format_of(out.instr[6:0])
            && out.illegal == !known_opcode(out.instr[6:0])
            && out.imm == imm_of(out.instr, format_of(out.instr[6:0])))
        else begin
            $error("Error at %0t: instr %h decoded as sel %0d illegal %b imm %h", $time,
                out.instr, out.imm_sel, out.illegal, out.imm);
            fail_count++;
        end

endmodule

/* verification/decode_stage_tb.sv */
`include "rv_decode_defines.svh"

module decode_stage_tb;

    import rv_decode_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_BUNDLES  = 64;
    // Slowest fetch takes 6 cycles
    // 12 per bundle leaves room for output stalls
    localparam int WATCHDOG_CYCLES = NUM_BUNDLES * 12 + RESET_CYCLES;

    // Opcodes for the memory image
    // Last entry is not an RV32I opcode
    localparam logic [6:0] OP_TABLE [12] = '{LUI, AUIPC, JAL, JALR, BRANCH, LOAD,
        STORE, OP_IMM, OP, MISC_MEM, SYSTEM, 7'b1111111};

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    logic     out_ready = 1'b0;
    logic     out_valid;
    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp = '0;
    decoded_t out;

    logic [31:0] mem [64];
    logic [31:0] lfsr = 32'h6e7c_a99e;
    // Slave wait state tracking
    logic        armed = 1'b0;
    logic [1:0]  wait_left = 2'd0;
    int          accepted = 0;
    int          tb_errors = 0;

    decode_stage DUT (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out       (out)
    );

    bind decode_stage decode_stage_checker u_checker (.*);

    always #4 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    task automatic draw_bits(input int n, output logic [31:0] v);
        int k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [5:0] word_index(input logic [31:0] adr);
        logic [31:0] off;
        off = adr - `RV_RESET_PC;
        return off[7:2];
    endfunction

    task automatic fill_memory();
        logic [31:0] r;
        logic [31:0] upper;
        int          i;
        int          pick;
        for (i = 0; i < 64; i++) begin
            // First words walk the table so every format shows up
            if (i < 12) begin
                pick = i;
            end else begin
                draw_bits(4, r);
                pick = int'(r % 12);
            end
            draw_bits(25, upper);
            mem[i] = {upper[24:0], OP_TABLE[pick]};
        end
    endtask

    task automatic print_counts();
        $display("Bundles accepted %0d, assertion errors %0d, data errors %0d",
            accepted, DUT.u_checker.fail_count, tb_errors);
    endtask

    // Instruction memory slave and output sink
    always @(posedge clk) begin
        logic [31:0] r;
        logic [1:0]  wl;
        draw_bits(2, r);
        // Sink stalls about one cycle in four
        out_ready <= (r[1:0] != 2'b00);
        if (rst) begin
            wb_rsp <= '0;
            armed  <= 1'b0;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack <= 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (armed) begin
                wl = wait_left;
            end else begin
                // New request waits 0 to 3 cycles
                draw_bits(2, r);
                wl = r[1:0];
            end
            if (wl == 2'd0) begin
                wb_rsp.ack <= 1'b1;
                wb_rsp.dat <= mem[word_index(wb_req.adr)];
                armed      <= 1'b0;
            end else begin
                armed     <= 1'b1;
                wait_left <= wl - 2'd1;
            end
        end
    end

    // Accepted word must be the one stored at its pc
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            assert (out.instr == mem[word_index(out.pc)]) else begin
                $display("Error at %0t: pc %h gave instr %h, memory holds %h", $time,
                    out.pc, out.instr, mem[word_index(out.pc)]);
                tb_errors++;
            end
            accepted <= accepted + 1;
        end
    end

    initial begin
        fill_memory();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        while (accepted < NUM_BUNDLES) @(posedge clk);
        print_counts();
        if (DUT.u_checker.fail_count + tb_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog fires between clock edges
    initial begin
        #(WATCHDOG_CYCLES * 8 + 2);
        $display("Timeout: only %0d of %0d bundles accepted in %0d cycles",
            accepted, NUM_BUNDLES, WATCHDOG_CYCLES);
        print_counts();
        $display("Simulation failed");
        $finish;
    end

endmodule
